// File: Makefile
SIM := obj_dir/Vtb_fetch_unit
SOURCES := $(shell cat flist.f)

.PHONY: all run clean

all: run

$(SIM): flist.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module tb_fetch_unit

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: flist.f
src/icache_pkg.sv
src/line_ram.sv
src/icache.sv
src/axil_read_master.sv
src/fetch_unit.sv
tests/axil_rom_model.sv
tests/tb_fetch_unit.sv

// File: src/axil_read_master.sv
`timescale 1ns/1ps

module axil_read_master
	import icache_pkg::*;
(
	input  logic                  i_clock,
	input  logic                  i_reset,

	input  logic                  i_miss_request,
	input  logic [ADDR_WIDTH-1:0] i_miss_address,
	output logic                  o_fill_valid,
	output logic [DATA_WIDTH-1:0] o_fill_data,

	output axil_ar_t              o_axil_ar,
	output logic                  o_axil_arvalid,
	input  logic                  i_axil_arready,
	input  axil_r_t               i_axil_r,
	input  logic                  i_axil_rvalid,
	output logic                  o_axil_rready
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA
	} state_t;

	state_t state;
	logic   miss_request_q;
	logic   start;

	// Only a fresh request starts a transaction
	assign start = (state == ST_IDLE) && i_miss_request && !miss_request_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state          <= ST_IDLE;
			miss_request_q <= 1'b0;
			o_axil_arvalid <= 1'b0;
			o_axil_rready  <= 1'b0;
			o_fill_valid   <= 1'b0;
		end else begin
			miss_request_q <= i_miss_request;
			o_fill_valid   <= 1'b0;  // One cycle pulse
			case (state)
				ST_IDLE: begin
					if (start) begin
						o_axil_arvalid <= 1'b1;
						state          <= ST_ADDR;
					end
				end

				ST_ADDR: begin
					if (i_axil_arready) begin
						o_axil_arvalid <= 1'b0;
						o_axil_rready  <= 1'b1;
						state          <= ST_DATA;
					end
				end

				ST_DATA: begin
					if (i_axil_rvalid) begin
						o_axil_rready <= 1'b0;
						o_fill_valid  <= 1'b1;
						state         <= ST_IDLE;
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (start) begin
			o_axil_ar.addr <= i_miss_address;  // Stable while arvalid waits
			o_axil_ar.prot <= AXIL_PROT_INSN;
		end
		if ((state == ST_DATA) && i_axil_rvalid) begin
			o_fill_data <= i_axil_r.data;  // Response code ignored
		end
	end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
	import icache_pkg::*;
(
	input  logic                  i_clock,
	input  logic                  i_reset,

	input  logic [TAG_WIDTH-1:0]  i_fetch_tag,
	input  logic [ADDR_WIDTH-1:0] i_fetch_address,
	output logic [TAG_WIDTH-1:0]  o_fetch_tag,
	output logic [DATA_WIDTH-1:0] o_fetch_data,

	output axil_ar_t              o_axil_ar,
	output logic                  o_axil_arvalid,
	input  logic                  i_axil_arready,
	input  axil_r_t               i_axil_r,
	input  logic                  i_axil_rvalid,
	output logic                  o_axil_rready
);

	logic                  miss_request;
	logic [ADDR_WIDTH-1:0] miss_address;
	logic                  fill_valid;
	logic [DATA_WIDTH-1:0] fill_data;

	icache i_icache (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_fetch_tag     (i_fetch_tag),
		.i_fetch_address (i_fetch_address),
		.o_fetch_tag     (o_fetch_tag),
		.o_fetch_data    (o_fetch_data),
		.o_miss_request  (miss_request),
		.o_miss_address  (miss_address),
		.i_fill_valid    (fill_valid),
		.i_fill_data     (fill_data)
	);

	axil_read_master i_axil_read_master (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_miss_request (miss_request),
		.i_miss_address (miss_address),
		.o_fill_valid   (fill_valid),
		.o_fill_data    (fill_data),
		.o_axil_ar      (o_axil_ar),
		.o_axil_arvalid (o_axil_arvalid),
		.i_axil_arready (i_axil_arready),
		.i_axil_r       (i_axil_r),
		.i_axil_rvalid  (i_axil_rvalid),
		.o_axil_rready  (o_axil_rready)
	);

endmodule

// File: src/icache.sv
`timescale 1ns/1ps

module icache
	import icache_pkg::*;
(
	input  logic                  i_clock,
	input  logic                  i_reset,

	input  logic [TAG_WIDTH-1:0]  i_fetch_tag,
	input  logic [ADDR_WIDTH-1:0] i_fetch_address,
	output logic [TAG_WIDTH-1:0]  o_fetch_tag,
	output logic [DATA_WIDTH-1:0] o_fetch_data,

	output logic                  o_miss_request,
	output logic [ADDR_WIDTH-1:0] o_miss_address,
	input  logic                  i_fill_valid,
	input  logic [DATA_WIDTH-1:0] i_fill_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WAIT_FILL,
		ST_WRITE_LINE
	} state_t;

	state_t state;
	logic [LINE_COUNT-1:0] valid;

	logic [INDEX_BITS-1:0] fetch_index;
	logic [INDEX_BITS-1:0] write_index;
	logic [INDEX_BITS-1:0] ram_index;
	logic                  write_enable;
	cache_line_t           write_line;
	cache_line_t           read_line;

	logic new_request;
	logic hit;
	logic fill_done;

	assign fetch_index = i_fetch_address[INDEX_BITS+1:2];  // Bits 1:0 always zero
	assign new_request = (i_fetch_tag != o_fetch_tag);
	assign hit         = (state == ST_LOOKUP) && (read_line.address == i_fetch_address);
	assign fill_done   = (state == ST_WAIT_FILL) && i_fill_valid;

	// Core may already present the next address while the line is written
	assign ram_index = write_enable ? write_index : fetch_index;

	assign o_miss_address = i_fetch_address;  // Held stable by the core until answered

	line_ram i_line_ram (
		.i_clock        (i_clock),
		.i_write_enable (write_enable),
		.i_index        (ram_index),
		.i_write_line   (write_line),
		.o_read_line    (read_line)
	);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state          <= ST_IDLE;
			valid          <= '0;
			o_fetch_tag    <= '0;
			o_miss_request <= 1'b0;
			write_enable   <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (new_request) begin
						if (valid[fetch_index]) begin
							state <= ST_LOOKUP;  // RAM output ready next cycle
						end else begin
							o_miss_request <= 1'b1;
							state          <= ST_WAIT_FILL;
						end
					end
				end

				ST_LOOKUP: begin
					if (hit) begin
						o_fetch_tag <= i_fetch_tag;
						state       <= ST_IDLE;
					end else begin
						o_miss_request <= 1'b1;  // Conflict with another address
						state          <= ST_WAIT_FILL;
					end
				end

				ST_WAIT_FILL: begin
					if (i_fill_valid) begin
						o_miss_request <= 1'b0;
						o_fetch_tag    <= i_fetch_tag;
						write_enable   <= 1'b1;
						state          <= ST_WRITE_LINE;
					end
				end

				ST_WRITE_LINE: begin
					valid[write_index] <= 1'b1;
					write_enable       <= 1'b0;
					state              <= ST_IDLE;
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (hit) begin
			o_fetch_data <= read_line.data;
		end
		if (fill_done) begin
			o_fetch_data       <= i_fill_data;  // Bus word goes straight out
			write_index        <= fetch_index;
			write_line.data    <= i_fill_data;
			write_line.address <= i_fetch_address;
		end
	end

endmodule

// File: src/icache_pkg.sv
package icache_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int TAG_WIDTH  = 4;

	// Direct mapped, one word per line
	localparam int INDEX_BITS = 10;
	localparam int LINE_COUNT = 1 << INDEX_BITS;

	// AxPROT: unprivileged, secure, instruction
	localparam logic [2:0] AXIL_PROT_INSN = 3'b100;

	// Full address kept next to the word, so a hit is an exact match
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [ADDR_WIDTH-1:0] address;
	} cache_line_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [2:0]            prot;
	} axil_ar_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [1:0]            resp;  // Not checked
	} axil_r_t;

endpackage

// File: src/line_ram.sv
`timescale 1ns/1ps

module line_ram
	import icache_pkg::*;
(
	input  logic                  i_clock,
	input  logic                  i_write_enable,
	input  logic [INDEX_BITS-1:0] i_index,
	input  cache_line_t           i_write_line,
	output cache_line_t           o_read_line
);

	cache_line_t mem [0:LINE_COUNT-1];

	// Read every cycle, old contents on a write
	always_ff @(posedge i_clock) begin
		if (i_write_enable) begin
			mem[i_index] <= i_write_line;
		end
		o_read_line <= mem[i_index];
	end

endmodule

// File: tests/axil_rom_model.sv
`timescale 1ns/1ps

module axil_rom_model
	import icache_pkg::*;
(
	input  logic     i_clock,
	input  logic     i_reset,
	input  axil_ar_t i_ar,
	input  logic     i_arvalid,
	output logic     o_arready,
	output axil_r_t  o_r,
	output logic     o_rvalid,
	input  logic     i_rready
);

	integer                seed;
	logic [ADDR_WIDTH-1:0] address;

	function automatic int random_delay();
		return {$random(seed)} % 4;  // 0 to 3 cycles
	endfunction

	task automatic next_cycle();
		@(posedge i_clock);
		#1;
	endtask

	initial begin
		seed      = 32'h35f0_71ff;
		o_arready = 1'b0;
		o_rvalid  = 1'b0;
		o_r       = '0;
		forever begin
			next_cycle();
			if (!i_reset && i_arvalid) begin
				repeat (random_delay()) next_cycle();
				address   = i_ar.addr;
				o_arready = 1'b1;
				next_cycle();  // AR accepted at this edge
				o_arready = 1'b0;
				repeat (random_delay()) next_cycle();
				while (!i_rready) next_cycle();
				o_r.data = ~{address[23:0], address[31:24]};
				o_r.resp = 2'b00;
				o_rvalid = 1'b1;
				next_cycle();
				o_rvalid = 1'b0;
			end
		end
	end

endmodule

// File: tests/tb_fetch_unit.sv
`timescale 1ns/1ps

module tb_fetch_unit
	import icache_pkg::*;
();

	localparam int CLOCK_PERIOD   = 100;
	localparam int COLD_COUNT     = 16;
	localparam int CONFLICT_COUNT = 12;
	localparam int MIXED_COUNT    = 24;
	localparam int RELOAD_COUNT   = 8;
	localparam int FETCH_COUNT    = 2 * COLD_COUNT + CONFLICT_COUNT + MIXED_COUNT + RELOAD_COUNT;

	localparam logic [ADDR_WIDTH-1:0] CODE_BASE     = 32'h0000_1000;
	localparam logic [ADDR_WIDTH-1:0] CONFLICT_BASE = 32'h0002_0040;  // Shares index 16 with CODE_BASE + 64

	logic                  i_clock;
	logic                  i_reset;
	logic [TAG_WIDTH-1:0]  i_fetch_tag;
	logic [ADDR_WIDTH-1:0] i_fetch_address;
	logic [TAG_WIDTH-1:0]  o_fetch_tag;
	logic [DATA_WIDTH-1:0] o_fetch_data;
	axil_ar_t              o_axil_ar;
	logic                  o_axil_arvalid;
	logic                  i_axil_arready;
	axil_r_t               i_axil_r;
	logic                  i_axil_rvalid;
	logic                  o_axil_rready;

	// Bench view of the cache contents
	bit                    model_valid [0:LINE_COUNT-1];
	logic [ADDR_WIDTH-1:0] model_address [0:LINE_COUNT-1];
	logic [ADDR_WIDTH-1:0] issued_address [0:(1 << TAG_WIDTH)-1];
	logic [ADDR_WIDTH-1:0] pending_address;
	logic [TAG_WIDTH-1:0]  next_tag;
	logic [TAG_WIDTH-1:0]  last_tag;
	logic                  last_was_miss;
	int                    ar_count = 0;
	int                    expected_ar_count;
	bit                    ar_waiting = 1'b0;
	axil_ar_t              held_ar;

	fetch_unit i_fetch_unit (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_fetch_tag     (i_fetch_tag),
		.i_fetch_address (i_fetch_address),
		.o_fetch_tag     (o_fetch_tag),
		.o_fetch_data    (o_fetch_data),
		.o_axil_ar       (o_axil_ar),
		.o_axil_arvalid  (o_axil_arvalid),
		.i_axil_arready  (i_axil_arready),
		.i_axil_r        (i_axil_r),
		.i_axil_rvalid   (i_axil_rvalid),
		.o_axil_rready   (o_axil_rready)
	);

	axil_rom_model i_rom (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_ar      (o_axil_ar),
		.i_arvalid (o_axil_arvalid),
		.o_arready (i_axil_arready),
		.o_r       (i_axil_r),
		.o_rvalid  (i_axil_rvalid),
		.i_rready  (o_axil_rready)
	);

	function automatic logic [DATA_WIDTH-1:0] expected_word(input logic [ADDR_WIDTH-1:0] address);
		return ~{address[23:0], address[31:24]};  // Inverse of rotate left by 8
	endfunction

	task automatic stop_failed();
		$display("Test FAILED");
		$fatal(1, "Simulation stopped after a failed check");
	endtask

	task automatic fail_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("FAIL at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
		stop_failed();
	endtask

	task automatic next_cycle();
		@(posedge i_clock);
		#1;
	endtask

	task automatic apply_reset();
		i_reset     = 1'b1;
		i_fetch_tag = '0;
		repeat (4) next_cycle();
		i_reset       = 1'b0;
		next_tag      = '0;
		last_was_miss = 1'b0;
		foreach (model_valid[i]) model_valid[i] = 1'b0;
		assert (o_fetch_tag == '0)
		else fail_value("o_fetch_tag", 64'(0), 64'(o_fetch_tag));
		assert (o_axil_arvalid == 1'b0)
		else fail_value("o_axil_arvalid", 64'(0), 64'(o_axil_arvalid));
		assert (o_axil_rready == 1'b0)
		else fail_value("o_axil_rready", 64'(0), 64'(o_axil_rready));
	endtask

	task automatic fetch(input logic [ADDR_WIDTH-1:0] address, input int gap);
		logic [INDEX_BITS-1:0] index;
		logic [TAG_WIDTH-1:0]  tag;
		logic                  predict_hit;
		int                    expected_latency;
		int                    ar_before;
		int                    cycles;
		index            = address[INDEX_BITS+1:2];
		predict_hit      = model_valid[index] && (model_address[index] == address);
		expected_latency = (last_was_miss && gap == 0) ? 3 : 2;  // Fill cycle comes first
		repeat (gap) next_cycle();
		tag                 = next_tag + TAG_WIDTH'(1);
		next_tag            = tag;
		issued_address[tag] = address;
		pending_address     = address;
		ar_before           = ar_count;
		i_fetch_address     = address;
		i_fetch_tag         = tag;
		cycles              = 0;
		do begin
			next_cycle();
			cycles++;
		end while (o_fetch_tag != tag && cycles < 20);
		if (o_fetch_tag != tag) begin
			$display("No answer to the fetch of address %h within 20 cycles", address);
			stop_failed();
		end
		if (predict_hit) begin
			assert (cycles == expected_latency)
			else fail_value("hit latency in cycles", 64'(expected_latency), 64'(cycles));
			assert (ar_count == ar_before)
			else fail_value("AR handshake count", 64'(ar_before), 64'(ar_count));
		end else begin
			assert (ar_count == ar_before + 1)
			else fail_value("AR handshake count", 64'(ar_before + 1), 64'(ar_count));
			expected_ar_count++;
		end
		model_valid[index]   = 1'b1;
		model_address[index] = address;
		last_was_miss        = !predict_hit;
	endtask

	initial begin
		i_clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
	end

	// Compare each answer with the rule for the address issued under its tag
	always @(negedge i_clock) begin
		if (i_reset) begin
			last_tag = o_fetch_tag;
		end else if (o_fetch_tag != last_tag) begin
			assert (o_fetch_data == expected_word(issued_address[o_fetch_tag]))
			else fail_value("o_fetch_data", 64'(expected_word(issued_address[o_fetch_tag])),
				64'(o_fetch_data));
			last_tag = o_fetch_tag;
		end
	end

	// AR channel monitor
	always @(negedge i_clock) begin
		if (!i_reset) begin
			if (ar_waiting && o_axil_arvalid) begin
				assert (o_axil_ar == held_ar)
				else fail_value("o_axil_ar", 64'(held_ar), 64'(o_axil_ar));
			end
			if (o_axil_arvalid && i_axil_arready) begin
				ar_count++;
				assert (o_axil_ar.addr == pending_address)
				else fail_value("o_axil_ar.addr", 64'(pending_address), 64'(o_axil_ar.addr));
				assert (o_axil_ar.prot == 3'b100)  // Instruction access
				else fail_value("o_axil_ar.prot", 64'(3'b100), 64'(o_axil_ar.prot));
			end
			ar_waiting = o_axil_arvalid && !i_axil_arready;
			held_ar    = o_axil_ar;
		end
	end

	initial begin
		#(FETCH_COUNT * 20 * CLOCK_PERIOD);
		$display("Watchdog timeout after %0d cycles, the fetch sequence did not finish",
			FETCH_COUNT * 20);
		stop_failed();
	end

	initial begin
		i_reset         = 1'b1;
		i_fetch_tag     = '0;
		i_fetch_address = '0;
		pending_address = '0;
		expected_ar_count = 0;
		foreach (issued_address[i]) issued_address[i] = '0;
		apply_reset();

		for (int i = 0; i < COLD_COUNT; i++) begin
			fetch(CODE_BASE + i * 4, i % 3);  // Cold misses
		end
		for (int i = 0; i < COLD_COUNT; i++) begin
			fetch(CODE_BASE + i * 4, i % 2);
		end
		for (int i = 0; i < CONFLICT_COUNT; i++) begin
			fetch(CONFLICT_BASE + (i % 2) * 4096, 0);  // Same index every time
		end
		for (int i = 0; i < MIXED_COUNT; i++) begin
			fetch(CODE_BASE + ((i * 7) % 24) * 4, 0);
		end

		apply_reset();  // Must invalidate every line
		for (int i = 0; i < RELOAD_COUNT; i++) begin
			fetch(CODE_BASE + i * 4, i % 2);
		end
		repeat (2) next_cycle();

		if (ar_count == expected_ar_count) begin
			$display("Test OK");
			$finish;
		end else begin
			fail_value("AR handshake total", 64'(expected_ar_count), 64'(ar_count));
		end
	end

endmodule
